/* hw/vec_core_pkg.sv */
// vector core shared types
package vec_core_pkg;

    // lane and scalar width
    localparam int lane_w = 16;

    // one lane, also the scalar register type
    typedef logic signed [lane_w-1:0] lane_t;

    // four lanes, lane 0 in the low bits
    typedef lane_t [3:0] vec_t;

    // register index into either file
    typedef logic [2:0] reg_idx_t;

    // alu op, taken from opcode[1:0]
    typedef enum logic [1:0] {
        op_add = 2'b00,
        op_sub = 2'b01,
        op_mul = 2'b10,
        op_xor = 2'b11
    } alu_op_e;

    // opcode class prefixes
    // vector op vector
    localparam logic [2:0] cls_vv     = 3'b000;
    // vector op broadcast scalar
    localparam logic [3:0] cls_vf     = 4'b0010;
    // scalar op 2-bit immediate
    localparam logic [3:0] cls_ii_imm = 4'b0011;
    // scalar op scalar on lane 0
    localparam logic [3:0] cls_ff     = 4'b0100;
    // scalar op scalar on the int alu
    localparam logic [2:0] cls_ii     = 3'b011;
    // scalar gets load value
    localparam logic [3:0] cls_li     = 4'b1000;

    // single special opcodes
    localparam logic [5:0] opc_reduce  = 6'b100100;
    localparam logic [5:0] opc_extract = 6'b100101;
    localparam logic [5:0] opc_insert  = 6'b100111;

    // lane op2 select codes
    // 3 feeds a zero, used for pass-through
    localparam logic [1:0] sel_vec2  = 2'd0;
    localparam logic [1:0] sel_scal2 = 2'd1;
    localparam logic [1:0] sel_neigh = 2'd2;
    localparam logic [1:0] sel_zero  = 2'd3;

    // decoded control, all zero means no-op
    typedef struct packed {
        logic            int_alu_op2_select;
        logic            int_alu_en;
        logic [3:0]      lane_op1_select;
        logic [3:0][1:0] lane_op2_select;
        logic [3:0]      lane_en;
        logic [2:0]      scalar_out_select;
        logic            vector_reduce_en;
        alu_op_e         alu_op;
        logic            scalar_write;
        logic            vector_write;
        logic            load_imm;
    } decode_t;

endpackage

/* hw/issue_if.sv */
// issue to execute bundle
`timescale 1ns/1ps

interface issue_if;
    import vec_core_pkg::*;

    // one-cycle pulse per instruction
    logic     valid;
    decode_t  ctrl;
    logic [1:0] immediate;
    reg_idx_t rd;
    // operands read in the issue cycle
    lane_t    scalar1;
    lane_t    scalar2;
    vec_t     vector1;
    vec_t     vector2;
    lane_t    load_value;

    modport issue (
        output valid, ctrl, immediate, rd, scalar1, scalar2, vector1, vector2, load_value
    );

    modport exec (
        input valid, ctrl, immediate, rd, scalar1, scalar2, vector1, vector2, load_value
    );

endinterface

/* hw/instruction_decode_unit.sv */
// opcode to control decode
`timescale 1ns/1ps

module instruction_decode_unit (
    input  logic [5:0]           opcode,
    input  logic [1:0]           immediate,
    output vec_core_pkg::decode_t ctrl
);
    import vec_core_pkg::*;

    always_comb begin
        // undefined opcodes fall through as all zero
        ctrl = '0;

        if (opcode[5:3] == cls_vv) begin
            // all lanes, v1 op v2
            ctrl.lane_en      = 4'b1111;
            ctrl.alu_op       = alu_op_e'(opcode[1:0]);
            ctrl.vector_write = 1'b1;
        end else if (opcode[5:2] == cls_vf) begin
            // all lanes, scalar 2 broadcast on op2
            ctrl.lane_en      = 4'b1111;
            for (int i = 0; i < 4; i++) begin
                ctrl.lane_op2_select[i] = sel_scal2;
            end
            ctrl.alu_op       = alu_op_e'(opcode[1:0]);
            ctrl.vector_write = 1'b1;
        end else if (opcode[5:2] == cls_ff) begin
            // lane 0 only, both operands from scalars
            ctrl.lane_en[0]         = 1'b1;
            ctrl.lane_op1_select[0] = 1'b1;
            ctrl.lane_op2_select[0] = sel_scal2;
            ctrl.scalar_out_select  = 3'b100;
            ctrl.alu_op             = alu_op_e'(opcode[1:0]);
            ctrl.scalar_write       = 1'b1;
        end else if (opcode[5:3] == cls_ii) begin
            // int alu, op2 from scalar 2
            ctrl.int_alu_en   = 1'b1;
            ctrl.alu_op       = alu_op_e'(opcode[1:0]);
            ctrl.scalar_write = 1'b1;
        end else if (opcode[5:2] == cls_ii_imm) begin
            // int alu, op2 from immediate
            ctrl.int_alu_en         = 1'b1;
            ctrl.int_alu_op2_select = 1'b1;
            ctrl.alu_op             = alu_op_e'(opcode[1:0]);
            ctrl.scalar_write       = 1'b1;
        end else if (opcode[5:2] == cls_li) begin
            // load value straight to scalar
            ctrl.load_imm     = 1'b1;
            ctrl.scalar_write = 1'b1;
        end else if (opcode == opc_reduce) begin
            // pairwise adds on lanes 0 and 2
            // the sum of both is built in execute
            ctrl.lane_en[0]         = 1'b1;
            ctrl.lane_en[2]         = 1'b1;
            ctrl.lane_op2_select[0] = sel_neigh;
            ctrl.lane_op2_select[2] = sel_neigh;
            ctrl.alu_op             = op_add;
            ctrl.vector_reduce_en   = 1'b1;
            ctrl.scalar_write       = 1'b1;
        end else if (opcode == opc_extract) begin
            // selected lane adds zero to v1
            ctrl.lane_en[immediate]         = 1'b1;
            ctrl.lane_op2_select[immediate] = sel_zero;
            ctrl.scalar_out_select          = {1'b1, immediate};
            ctrl.alu_op                     = op_add;
            ctrl.scalar_write               = 1'b1;
        end else if (opcode == opc_insert) begin
            // scalar 1 into one lane, rest keep v1
            ctrl.lane_en[immediate]         = 1'b1;
            ctrl.lane_op1_select[immediate] = 1'b1;
            ctrl.lane_op2_select[immediate] = sel_zero;
            ctrl.alu_op                     = op_add;
            ctrl.vector_write               = 1'b1;
        end
    end

endmodule

/* hw/register_file.sv */
// two-read one-write register file
`timescale 1ns/1ps

module register_file #(
    parameter int  NUM_REGS = 8,
    parameter type entry_t  = logic [15:0]
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  vec_core_pkg::reg_idx_t rd_addr1,
    input  vec_core_pkg::reg_idx_t rd_addr2,
    output entry_t                rd_data1,
    output entry_t                rd_data2,
    input  logic                  we,
    input  vec_core_pkg::reg_idx_t wr_addr,
    input  entry_t                wr_data
);

    entry_t mem [NUM_REGS];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                mem[i] <= '0;
            end
        end else if (we) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // async reads, pending write wins
    // lets a dependent instruction issue right behind its producer
    assign rd_data1 = (we && wr_addr == rd_addr1) ? wr_data : mem[rd_addr1];
    assign rd_data2 = (we && wr_addr == rd_addr2) ? wr_data : mem[rd_addr2];

    // write target must exist
    a_wr_addr_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        we |-> (int'(wr_addr) < NUM_REGS)
    );

endmodule

/* hw/issue_stage.sv */
// instruction issue stage
`timescale 1ns/1ps

module issue_stage #(
    parameter int NUM_REGS = 8
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   instr_valid,
    input  logic [5:0]             opcode,
    input  logic [1:0]             immediate,
    input  vec_core_pkg::reg_idx_t rd,
    input  vec_core_pkg::reg_idx_t rs1,
    input  vec_core_pkg::reg_idx_t rs2,
    input  vec_core_pkg::lane_t    load_value,
    output vec_core_pkg::reg_idx_t s_rd_addr1,
    output vec_core_pkg::reg_idx_t s_rd_addr2,
    output vec_core_pkg::reg_idx_t v_rd_addr1,
    output vec_core_pkg::reg_idx_t v_rd_addr2,
    input  vec_core_pkg::lane_t    s_rd_data1,
    input  vec_core_pkg::lane_t    s_rd_data2,
    input  vec_core_pkg::vec_t     v_rd_data1,
    input  vec_core_pkg::vec_t     v_rd_data2,
    issue_if.issue                 iss
);
    import vec_core_pkg::*;

    decode_t dec;
    logic    dec_writes;

    instruction_decode_unit u_decode (
        .opcode    (opcode),
        .immediate (immediate),
        .ctrl      (dec)
    );

    // rs1/rs2 go to both files
    assign s_rd_addr1 = rs1;
    assign s_rd_addr2 = rs2;
    assign v_rd_addr1 = rs1;
    assign v_rd_addr2 = rs2;

    // undefined opcodes write nothing, so they never issue
    assign dec_writes = dec.scalar_write | dec.vector_write;

    // control state
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            iss.valid <= 1'b0;
            iss.ctrl  <= '0;
        end else begin
            iss.valid <= instr_valid & dec_writes;
            if (instr_valid) begin
                iss.ctrl <= dec;
            end
        end
    end

    // operand payload
    always_ff @(posedge clk) begin
        if (instr_valid) begin
            iss.immediate  <= immediate;
            iss.rd         <= rd;
            iss.scalar1    <= s_rd_data1;
            iss.scalar2    <= s_rd_data2;
            iss.vector1    <= v_rd_data1;
            iss.vector2    <= v_rd_data2;
            iss.load_value <= load_value;
        end
    end

    // a sampled instruction issues exactly when its decode is non-zero
    a_no_empty_issue: assert property (
        @(posedge clk) disable iff (!rst_n)
        instr_valid |=> (iss.valid == (iss.ctrl != '0))
    );

    // indices in range of the configured files
    a_idx_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        instr_valid |-> (int'(rd) < NUM_REGS && int'(rs1) < NUM_REGS
                         && int'(rs2) < NUM_REGS)
    );

endmodule

/* hw/lane_alu.sv */
// 16-bit lane alu
`timescale 1ns/1ps

module lane_alu (
    input  logic                  en,
    input  vec_core_pkg::alu_op_e op,
    input  vec_core_pkg::lane_t   a,
    input  vec_core_pkg::lane_t   b,
    output vec_core_pkg::lane_t   y
);
    import vec_core_pkg::*;

    lane_t res;

    always_comb begin
        case (op)
            op_add:  res = a + b;
            op_sub:  res = a - b;
            // 16-bit context keeps the low half of the product
            op_mul:  res = a * b;
            op_xor:  res = a ^ b;
            default: res = '0;
        endcase
    end

    // idle lanes drive zero
    assign y = en ? res : '0;

endmodule

/* hw/execute_stage.sv */
// execute and writeback stage
`timescale 1ns/1ps

module execute_stage (
    input  logic                   clk,
    input  logic                   rst_n,
    issue_if.exec                  iss,
    output logic                   s_we,
    output logic                   v_we,
    output vec_core_pkg::reg_idx_t wr_addr,
    output vec_core_pkg::lane_t    s_wr_data,
    output vec_core_pkg::vec_t     v_wr_data,
    output logic                   result_valid,
    output logic                   result_is_vector,
    output vec_core_pkg::lane_t    scalar_result,
    output vec_core_pkg::vec_t     vector_result
);
    import vec_core_pkg::*;

    vec_t  op1;
    vec_t  op2;
    vec_t  lane_y;
    lane_t int_b;
    lane_t int_y;
    lane_t reduce_sum;
    lane_t scalar_next;
    vec_t  vector_next;

    // per-lane operand muxes
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            op1[i] = iss.ctrl.lane_op1_select[i] ? iss.scalar1 : iss.vector1[i];
            case (iss.ctrl.lane_op2_select[i])
                sel_vec2:  op2[i] = iss.vector2[i];
                sel_scal2: op2[i] = iss.scalar2;
                // pair neighbour, lane 0 takes 1 and lane 2 takes 3
                sel_neigh: op2[i] = iss.vector1[i ^ 1];
                default:   op2[i] = '0;
            endcase
        end
    end

    for (genvar g = 0; g < 4; g++) begin : g_lane
        lane_alu u_lane (
            .en (iss.ctrl.lane_en[g]),
            .op (iss.ctrl.alu_op),
            .a  (op1[g]),
            .b  (op2[g]),
            .y  (lane_y[g])
        );
    end

    // int alu, op2 is scalar 2 or zero-extended immediate
    assign int_b = iss.ctrl.int_alu_op2_select ? lane_t'({14'b0, iss.immediate}) : iss.scalar2;

    lane_alu u_int_alu (
        .en (iss.ctrl.int_alu_en),
        .op (iss.ctrl.alu_op),
        .a  (iss.scalar1),
        .b  (int_b),
        .y  (int_y)
    );

    // lanes 0 and 2 already hold the pair sums
    assign reduce_sum = lane_y[0] + lane_y[2];

    always_comb begin
        if (iss.ctrl.load_imm) begin
            scalar_next = iss.load_value;
        end else if (iss.ctrl.vector_reduce_en) begin
            scalar_next = reduce_sum;
        end else if (iss.ctrl.scalar_out_select[2]) begin
            scalar_next = lane_y[iss.ctrl.scalar_out_select[1:0]];
        end else begin
            scalar_next = int_y;
        end
        // disabled lanes keep v1, which covers insert
        for (int i = 0; i < 4; i++) begin
            vector_next[i] = iss.ctrl.lane_en[i] ? lane_y[i] : iss.vector1[i];
        end
    end

    // writeback lands on the next edge
    assign s_we      = iss.valid & iss.ctrl.scalar_write;
    assign v_we      = iss.valid & iss.ctrl.vector_write;
    assign wr_addr   = iss.rd;
    assign s_wr_data = scalar_next;
    assign v_wr_data = vector_next;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result_valid     <= 1'b0;
            result_is_vector <= 1'b0;
            scalar_result    <= '0;
            vector_result    <= '0;
        end else begin
            result_valid <= iss.valid;
            if (iss.valid) begin
                result_is_vector <= iss.ctrl.vector_write;
                scalar_result    <= scalar_next;
                vector_result    <= vector_next;
            end
        end
    end

    // each issued instruction writes exactly one file
    a_one_write: assert property (
        @(posedge clk) disable iff (!rst_n)
        iss.valid |-> (s_we ^ v_we)
    );

endmodule

/* hw/vec_core_top.sv */
// vector core top level
`timescale 1ns/1ps

module vec_core_top #(
    parameter int NUM_REGS = 8
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   instr_valid,
    input  logic [5:0]             opcode,
    input  logic [1:0]             immediate,
    input  vec_core_pkg::reg_idx_t rd,
    input  vec_core_pkg::reg_idx_t rs1,
    input  vec_core_pkg::reg_idx_t rs2,
    input  vec_core_pkg::lane_t    load_value,
    output logic                   result_valid,
    output logic                   result_is_vector,
    output vec_core_pkg::lane_t    scalar_result,
    output vec_core_pkg::vec_t     vector_result
);
    import vec_core_pkg::*;

    // read side
    reg_idx_t s_rd_addr1, s_rd_addr2, v_rd_addr1, v_rd_addr2;
    lane_t    s_rd_data1, s_rd_data2;
    vec_t     v_rd_data1, v_rd_data2;
    // writeback side
    logic     s_we, v_we;
    reg_idx_t wr_addr;
    lane_t    s_wr_data;
    vec_t     v_wr_data;

    issue_if iss_bus ();

    issue_stage #(.NUM_REGS(NUM_REGS)) u_issue (
        .clk, .rst_n, .instr_valid, .opcode, .immediate, .rd, .rs1, .rs2, .load_value,
        .s_rd_addr1, .s_rd_addr2, .v_rd_addr1, .v_rd_addr2,
        .s_rd_data1, .s_rd_data2, .v_rd_data1, .v_rd_data2,
        .iss (iss_bus.issue)
    );

    register_file #(.NUM_REGS(NUM_REGS), .entry_t(lane_t)) u_scalar_rf (
        .clk, .rst_n, .rd_addr1(s_rd_addr1), .rd_addr2(s_rd_addr2),
        .rd_data1(s_rd_data1), .rd_data2(s_rd_data2),
        .we(s_we), .wr_addr, .wr_data(s_wr_data)
    );

    register_file #(.NUM_REGS(NUM_REGS), .entry_t(vec_t)) u_vector_rf (
        .clk, .rst_n, .rd_addr1(v_rd_addr1), .rd_addr2(v_rd_addr2),
        .rd_data1(v_rd_data1), .rd_data2(v_rd_data2),
        .we(v_we), .wr_addr, .wr_data(v_wr_data)
    );

    execute_stage u_exec (
        .clk, .rst_n, .iss (iss_bus.exec), .s_we, .v_we, .wr_addr, .s_wr_data, .v_wr_data,
        .result_valid, .result_is_vector, .scalar_result, .vector_result
    );

endmodule

/* dv/vec_core_tb.sv */
// vector core testbench
`timescale 1ns/1ps

module vec_core_tb;

    localparam int num_regs   = 8;
    localparam int max_instr  = 400;
    // one instruction slot per 4 ns clock, plus margin for reset and drain
    localparam int timeout_ns = max_instr * 4 + 200;

    logic        clk;
    logic        rst_n;
    logic        instr_valid;
    logic [5:0]  opcode;
    logic [1:0]  immediate;
    logic [2:0]  rd;
    logic [2:0]  rs1;
    logic [2:0]  rs2;
    logic [15:0] load_value;
    logic        result_valid;
    logic        result_is_vector;
    logic [15:0] scalar_result;
    logic [63:0] vector_result;

    // shadow register files
    logic [15:0] s_model [num_regs];
    logic [63:0] v_model [num_regs];

    // expected results, oldest first
    int          exp_due  [$];
    logic        exp_vec  [$];
    logic [63:0] exp_val  [$];
    string       exp_name [$];

    integer     seed;
    int         cycle_cnt = 0;
    int         errors;
    int         checks;
    logic [2:0] last_rd;
    string      phase;

    vec_core_top #(.NUM_REGS(num_regs)) uut (
        .clk, .rst_n, .instr_valid, .opcode, .immediate, .rd, .rs1, .rs2, .load_value,
        .result_valid, .result_is_vector, .scalar_result, .vector_result
    );

    always #2 clk = ~clk;

    // edge count, used to time each result
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    initial begin
        #(timeout_ns);
        $display("timeout: run did not finish within %0d ns", timeout_ns);
        $display("Verification failed");
        $finish;
    end

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // add, sub, low half of product, xor
    function automatic logic [15:0] alu_ref(input logic [1:0] op, input logic [15:0] a,
                                            input logic [15:0] b);
        logic [31:0] prod;
        prod = a * b;
        case (op)
            2'd0:    return a + b;
            2'd1:    return a - b;
            2'd2:    return prod[15:0];
            default: return a ^ b;
        endcase
    endfunction

    task automatic compare_value(input string name, input logic [63:0] expected,
                                 input logic [63:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Fail %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic drop_front();
        void'(exp_due.pop_front());
        void'(exp_vec.pop_front());
        void'(exp_val.pop_front());
        void'(exp_name.pop_front());
    endtask

    // class index 0..8 is a defined class, anything else an undefined opcode
    task automatic pick_opcode(input int cls, output logic [5:0] opc);
        case (cls)
            0: opc = {3'b000, 3'(rand_below(8))};
            1: opc = {4'b0010, 2'(rand_below(4))};
            2: opc = {4'b0100, 2'(rand_below(4))};
            3: opc = {3'b011, 3'(rand_below(8))};
            4: opc = {4'b0011, 2'(rand_below(4))};
            5: opc = {4'b1000, 2'(rand_below(4))};
            6: opc = 6'b100100;
            7: opc = 6'b100101;
            8: opc = 6'b100111;
            default: begin
                case (rand_below(4))
                    0: opc = {4'b0101, 2'(rand_below(4))};
                    1: opc = 6'b100110;
                    2: opc = {3'b101, 3'(rand_below(8))};
                    default: opc = {2'b11, 4'(rand_below(16))};
                endcase
            end
        endcase
    endtask

    // apply one instruction to the shadow state and queue its result
    task automatic model_instr(input logic [5:0] opc, input logic [1:0] imm,
                               input logic [2:0] d, input logic [2:0] s_a,
                               input logic [2:0] s_b, input logic [15:0] ld);
        logic [63:0] v1;
        logic [63:0] v2;
        logic [63:0] vr;
        logic [15:0] s1;
        logic [15:0] s2;
        logic [15:0] sr;
        logic        is_vec;
        logic        defined;
        string       cls;
        v1 = v_model[s_a];
        v2 = v_model[s_b];
        s1 = s_model[s_a];
        s2 = s_model[s_b];
        vr = '0;
        sr = '0;
        is_vec = 1'b0;
        defined = 1'b1;
        cls = "";
        casez (opc)
            6'b000???: begin
                cls = "vv";
                is_vec = 1'b1;
                for (int i = 0; i < 4; i++) begin
                    vr[16*i +: 16] = alu_ref(opc[1:0], v1[16*i +: 16], v2[16*i +: 16]);
                end
            end
            6'b0010??: begin
                // scalar 2 on every lane
                cls = "vf";
                is_vec = 1'b1;
                for (int i = 0; i < 4; i++) begin
                    vr[16*i +: 16] = alu_ref(opc[1:0], v1[16*i +: 16], s2);
                end
            end
            6'b0011??: begin
                cls = "ii_imm";
                sr = alu_ref(opc[1:0], s1, {14'b0, imm});
            end
            6'b0100??: begin
                cls = "ff";
                sr = alu_ref(opc[1:0], s1, s2);
            end
            6'b011???: begin
                cls = "ii";
                sr = alu_ref(opc[1:0], s1, s2);
            end
            6'b1000??: begin
                cls = "li";
                sr = ld;
            end
            6'b100100: begin
                cls = "reduce";
                sr = v1[15:0] + v1[31:16] + v1[47:32] + v1[63:48];
            end
            6'b100101: begin
                cls = "extract";
                sr = v1[16*imm +: 16];
            end
            6'b100111: begin
                // only the selected lane changes
                cls = "insert";
                is_vec = 1'b1;
                vr = v1;
                vr[16*imm +: 16] = s1;
            end
            default: defined = 1'b0;
        endcase
        if (defined) begin
            if (is_vec) begin
                v_model[d] = vr;
            end else begin
                s_model[d] = sr;
            end
            // sampled at the next edge, reported after the one after
            exp_due.push_back(cycle_cnt + 2);
            exp_vec.push_back(is_vec);
            exp_val.push_back(is_vec ? vr : {48'b0, sr});
            exp_name.push_back({phase, " ", cls});
        end
    endtask

    // one clock slot, inputs change just after the rising edge
    task automatic issue_slot(input logic valid, input logic [5:0] opc, input logic [1:0] imm,
                              input logic [2:0] d, input logic [2:0] s_a,
                              input logic [2:0] s_b, input logic [15:0] ld);
        @(posedge clk);
        #1;
        instr_valid = valid;
        opcode      = opc;
        immediate   = imm;
        rd          = d;
        rs1         = s_a;
        rs2         = s_b;
        load_value  = ld;
        if (valid) begin
            model_instr(opc, imm, d, s_a, s_b, ld);
            last_rd = d;
        end
    endtask

    // results are stable mid-cycle
    always @(negedge clk) begin
        if (result_valid === 1'b1) begin
            if (exp_due.size() == 0) begin
                errors++;
                $display("error: result_valid high at cycle %0d with nothing outstanding",
                         cycle_cnt);
            end else begin
                if (exp_due[0] != cycle_cnt) begin
                    errors++;
                    $display("error: %s result came at cycle %0d but was due at cycle %0d",
                             exp_name[0], cycle_cnt, exp_due[0]);
                end
                compare_value({exp_name[0], " kind"}, 64'(exp_vec[0]), 64'(result_is_vector));
                if (exp_vec[0]) begin
                    compare_value(exp_name[0], exp_val[0], vector_result);
                end else begin
                    compare_value(exp_name[0], exp_val[0], {48'b0, scalar_result});
                end
                drop_front();
            end
        end else if (exp_due.size() != 0 && exp_due[0] <= cycle_cnt) begin
            errors++;
            $display("error: no result_valid for %s due at cycle %0d", exp_name[0], exp_due[0]);
            drop_front();
        end
    end

    initial begin
        logic [5:0] opc;
        logic       valid_bit;
        seed        = 32'h5f63;
        errors      = 0;
        checks      = 0;
        last_rd     = '0;
        phase       = "reset";
        clk         = 1'b0;
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        opcode      = '0;
        immediate   = '0;
        rd          = '0;
        rs1         = '0;
        rs2         = '0;
        load_value  = '0;
        for (int i = 0; i < num_regs; i++) begin
            s_model[i] = '0;
            v_model[i] = '0;
        end
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // garbage on the fields while instr_valid is low
        phase = "idle";
        repeat (8) begin
            issue_slot(1'b0, 6'(rand_below(64)), 2'(rand_below(4)), 3'(rand_below(8)),
                       3'(rand_below(8)), 3'(rand_below(8)), 16'(rand_below(65536)));
        end

        // load a scalar then insert it, back to back through the bypass
        phase = "fill";
        for (int r = 0; r < num_regs; r++) begin
            for (int l = 0; l < 4; l++) begin
                issue_slot(1'b1, 6'b100000, 2'd0, 3'(r), 3'd0, 3'd0, 16'(rand_below(65536)));
                issue_slot(1'b1, 6'b100111, 2'(l), 3'(r), 3'(r), 3'd0, 16'd0);
            end
        end

        phase = "random";
        repeat (180) begin
            valid_bit = (rand_below(5) != 0);
            pick_opcode(rand_below(10), opc);
            issue_slot(valid_bit, opc, 2'(rand_below(4)), 3'(rand_below(8)),
                       3'(rand_below(8)), 3'(rand_below(8)), 16'(rand_below(65536)));
        end

        // each source is the previous destination
        phase = "chain";
        repeat (60) begin
            pick_opcode(rand_below(9), opc);
            issue_slot(1'b1, opc, 2'(rand_below(4)), 3'(rand_below(8)), last_rd, last_rd,
                       16'(rand_below(65536)));
        end

        // add-immediate zero returns each scalar
        phase = "readback";
        for (int r = 0; r < num_regs; r++) begin
            issue_slot(1'b1, 6'b001100, 2'd0, 3'(r), 3'(r), 3'd0, 16'd0);
        end
        for (int r = 0; r < num_regs; r++) begin
            for (int l = 0; l < 4; l++) begin
                issue_slot(1'b1, 6'b100101, 2'(l), 3'd0, 3'(r), 3'd0, 16'd0);
            end
        end

        phase = "drain";
        repeat (4) begin
            issue_slot(1'b0, 6'd0, 2'd0, 3'd0, 3'd0, 3'd0, 16'd0);
        end
        if (exp_due.size() != 0) begin
            errors++;
            $display("error: %0d expected results never arrived", exp_due.size());
        end

        $display("errors: %0d in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* project.f */
hw/vec_core_pkg.sv
hw/issue_if.sv
hw/instruction_decode_unit.sv
hw/register_file.sv
hw/issue_stage.sv
hw/lane_alu.sv
hw/execute_stage.sv
hw/vec_core_top.sv
dv/vec_core_tb.sv
